//--- rv64_ex_pipe.f
rv64_pkg.sv
rv64_alu.sv
rv64_decode.sv
rv64_execute.sv
rv64_result.sv
rv64_ex_pipe.sv
rv64_ex_pipe_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module rv64_ex_pipe_tb \
  -f rv64_ex_pipe.f -o sim &&
./obj_dir/sim | tee sim.log &&
grep -q "RESULT: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- rv64_ex_pipe_tb.sv
// directed testbench, expects rv64_ex_pipe with a 3 cycle latency and one retire per cycle
module rv64_ex_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import rv64_pkg::*;

  localparam int CLK_NS = 20;
  localparam int N_INST = 287; // 40 + 13 + 10 + 4 + 200 + 20
  localparam int WD_NS  = (N_INST * 20 + 200) * CLK_NS;

  typedef struct packed {
    gpr_addr_t   rd;
    logic        gpr_wen;
    word_t       gpr_wdata;
    logic        csr_wen;
    word_t       csr_wdata;
    logic        ebreak;
    logic        invalid;
    logic        lat;     // check the 3 cycle latency
    logic [31:0] acc_cyc; // cycle of acceptance
  } exp_t;

  logic      i_clk;
  logic      i_arst_n;
  logic      i_inst_valid;
  inst_t     i_inst;
  word_t     i_pc;
  word_t     i_rs1data;
  word_t     i_rs2data;
  word_t     i_csrrdata;
  logic      i_ready = 1'b1;
  logic      o_inst_ready;
  logic      o_valid;
  gpr_addr_t o_rd;
  logic      o_gpr_wen;
  word_t     o_gpr_wdata;
  logic      o_csr_wen;
  word_t     o_csr_wdata;
  logic      o_ebreak;
  logic      o_invalid;

  exp_t         exp_q[$];
  exp_t         got;
  string        cur_test = "reset";
  int           n_checks = 0;
  int           n_errors = 0;
  int           err_start;
  logic [31:0]  cyc = '0;
  logic         stall_en = 1'b0;
  logic         hold_chk = 1'b0;
  logic [136:0] held;
  logic [136:0] snap;
  word_t        pc_r = 64'h0000_0000_8000_0000;

  rv64_ex_pipe i_rv64_ex_pipe (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS / 2) i_clk = ~i_clk;
  end

  always @(negedge i_clk) cyc = cyc + 1;

  // random back-pressure only while a test asks for it
  always @(negedge i_clk) i_ready = stall_en ? 1'($urandom) : 1'b1;

  initial begin
    #(WD_NS);
    $display("ERROR: watchdog expired in test %s, the pipeline stopped retiring", cur_test);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic word_t sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // reference model from the isa rules
  function automatic exp_t model(input inst_t inst, input word_t pc, input word_t rs1,
                                 input word_t rs2, input word_t csr);
    exp_t        e;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rs1f;
    logic        is_r;
    logic        legal;
    word_t       imm;
    word_t       b;
    word_t       src;
    logic [31:0] w;
    e     = '0;
    opc   = inst[6:0];
    f7    = inst[31:25];
    f3    = inst[14:12];
    rs1f  = inst[19:15];
    is_r  = (opc == OPC_OP) || (opc == OPC_OP_32);
    imm   = {{52{inst[31]}}, inst[31:20]};
    b     = is_r ? rs2 : imm;
    legal = 1'b1;
    e.rd      = inst[11:7];
    e.gpr_wen = 1'b1;
    case (opc)
      OPC_OP, OPC_OP_IMM: begin
        if (is_r) legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (f3 == 3'd1) legal = (inst[31:26] == 6'b0);
        else if (f3 == 3'd5) legal = (inst[31:26] == 6'b0) || (inst[31:26] == 6'b010000);
        case (f3)
          3'd0: e.gpr_wdata = (is_r && f7[5]) ? rs1 - b : rs1 + b;
          3'd1: e.gpr_wdata = rs1 << b[5:0];
          3'd2: e.gpr_wdata = 64'($signed(rs1) < $signed(b));
          3'd3: e.gpr_wdata = 64'(rs1 < b);
          3'd4: e.gpr_wdata = rs1 ^ b;
          3'd5: begin
            if (f7[5]) e.gpr_wdata = $signed(rs1) >>> b[5:0];
            else       e.gpr_wdata = rs1 >> b[5:0];
          end
          3'd6: e.gpr_wdata = rs1 | b;
          default: e.gpr_wdata = rs1 & b;
        endcase
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        if (is_r) legal = ((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) &&
                          (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
        else legal = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                     (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
        case (f3)
          3'd0: w = (is_r && f7[5]) ? rs1[31:0] - b[31:0] : rs1[31:0] + b[31:0];
          3'd1: w = rs1[31:0] << b[4:0];
          3'd5: begin
            if (f7[5]) w = $signed(rs1[31:0]) >>> b[4:0];
            else       w = rs1[31:0] >> b[4:0];
          end
          default: w = '0;
        endcase
        e.gpr_wdata = sext32(w);
      end
      OPC_LUI:   e.gpr_wdata = sext32({inst[31:12], 12'b0});
      OPC_AUIPC: e.gpr_wdata = pc + sext32({inst[31:12], 12'b0});
      OPC_JAL:   e.gpr_wdata = pc + 64'd4;
      OPC_JALR: begin
        legal       = (f3 == 3'd0);
        e.gpr_wdata = pc + 64'd4;
      end
      OPC_SYSTEM: begin
        if (f3[1:0] == 2'b00) begin
          e.gpr_wen = 1'b0;
          e.ebreak  = (inst == 32'h0010_0073);
          legal     = e.ebreak; // ecall and the rest are not handled
        end else begin
          src         = f3[2] ? {59'b0, rs1f} : rs1;
          e.gpr_wdata = csr; // old value goes to rd
          case (f3[1:0])
            2'b01:   e.csr_wdata = src;
            2'b10:   e.csr_wdata = csr | src;
            default: e.csr_wdata = csr & ~src;
          endcase
          e.csr_wen = (f3[1:0] == 2'b01) || (rs1f != 5'd0);
        end
      end
      default: legal = 1'b0;
    endcase
    e.invalid = !legal;
    if (!legal) begin
      e.gpr_wen = 1'b0;
      e.csr_wen = 1'b0;
    end
    if (e.rd == 5'd0) e.gpr_wen = 1'b0;
    return e;
  endfunction

  function automatic inst_t rand_alu_inst();
    logic [2:0]  f3;
    logic [11:0] imm;
    f3  = 3'($urandom);
    imm = 12'($urandom);
    if (1'($urandom)) begin
      return enc_r(((f3 == 3'd0 || f3 == 3'd5) && 1'($urandom)) ? 7'h20 : 7'h00,
                   5'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OP);
    end
    if (f3 == 3'd1) imm[11:6] = 6'b0;
    if (f3 == 3'd5) imm[11:6] = 1'($urandom) ? 6'b010000 : 6'b0;
    return enc_i(imm, 5'($urandom), f3, 5'($urandom), OPC_OP_IMM);
  endfunction

  task automatic check_val(input string field, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("FAIL %s %s expected %h actual %h", cur_test, field, exp, act);
      n_errors++;
    end
  endtask

  task automatic send(input inst_t inst, input word_t rs1, input word_t rs2, input word_t csr,
                      input logic lat);
    exp_t e;
    int   waits;
    e = model(inst, pc_r, rs1, rs2, csr);
    @(negedge i_clk);
    i_inst_valid = 1'b1;
    i_inst       = inst;
    i_pc         = pc_r;
    i_rs1data    = rs1;
    i_rs2data    = rs2;
    i_csrrdata   = csr;
    waits        = 0;
    @(posedge i_clk);
    while (!o_inst_ready) begin
      waits++;
      @(posedge i_clk);
    end
    e.lat     = lat;
    e.acc_cyc = cyc;
    exp_q.push_back(e);
    pc_r = pc_r + 64'd4;
    if (lat) begin
      n_checks++;
      assert (waits == 0) else begin
        $display("ERROR: %s input was stalled during a back-to-back stream", cur_test);
        n_errors++;
      end
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = n_errors;
  endtask

  task automatic end_test();
    @(negedge i_clk);
    i_inst_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge i_clk);
    @(posedge i_clk);
    if (n_errors == err_start) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, n_errors - err_start);
  endtask

  assign snap = {o_rd, o_gpr_wen, o_gpr_wdata, o_csr_wen, o_csr_wdata, o_ebreak, o_invalid};

  // retire monitor and stall hold check
  always @(posedge i_clk) begin
    if (i_arst_n) begin
      if (hold_chk) begin
        n_checks++;
        assert (snap == held) else begin
          $display("ERROR: %s outputs changed while the output was stalled", cur_test);
          n_errors++;
        end
      end
      hold_chk = o_valid && !i_ready;
      held     = snap;
      if (o_valid && i_ready) begin
        n_checks++;
        assert (exp_q.size() != 0) else begin
          $display("ERROR: %s retired an instruction that was never sent", cur_test);
          n_errors++;
        end
        if (exp_q.size() != 0) begin
          got = exp_q.pop_front();
          check_val("gpr_wen", 64'(got.gpr_wen), 64'(o_gpr_wen));
          if (got.gpr_wen) begin
            check_val("rd", 64'(got.rd), 64'(o_rd));
            check_val("gpr_wdata", got.gpr_wdata, o_gpr_wdata);
          end
          check_val("csr_wen", 64'(got.csr_wen), 64'(o_csr_wen));
          if (got.csr_wen) check_val("csr_wdata", got.csr_wdata, o_csr_wdata);
          check_val("ebreak", 64'(got.ebreak), 64'(o_ebreak));
          check_val("invalid", 64'(got.invalid), 64'(o_invalid));
          if (got.lat) check_val("latency", 64'd3, 64'(cyc - got.acc_cyc));
        end
      end
    end
  end

  task automatic test_basic();
    inst_t inst;
    start_test("basic");
    for (int k = 0; k < 40; k++) begin
      inst = rand_alu_inst();
      if (k == 0) inst[11:7] = 5'd0; // x0 destination
      send(inst, {$urandom, $urandom}, {$urandom, $urandom}, '0, 1'b0);
    end
    end_test();
  endtask

  task automatic test_word();
    start_test("word");
    send(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd1, OPC_OP_32), 64'h7fff_ffff, 64'd1, '0, 1'b0);
    send(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd2, OPC_OP_32), 64'd0, 64'd1, '0, 1'b0);
    send(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd3, OPC_OP_32), 64'd1, 64'hffff_ffff_ffff_ffdf,
         '0, 1'b0);
    send(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd4, OPC_OP_32), 64'hffff_ffff_8000_0000, 64'd4,
         '0, 1'b0);
    send(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd5, OPC_OP_32), 64'h0000_0000_8000_0000, 64'd4,
         '0, 1'b0);
    send(enc_i(12'h800, 5'd1, 3'd0, 5'd6, OPC_OP_IMM_32), {$urandom, $urandom}, '0, '0, 1'b0);
    send(enc_i(12'h010, 5'd1, 3'd1, 5'd7, OPC_OP_IMM_32), {$urandom, $urandom}, '0, '0, 1'b0);
    send(enc_i(12'h001, 5'd1, 3'd5, 5'd8, OPC_OP_IMM_32), 64'hffff_ffff_ffff_fff0, '0, '0,
         1'b0);
    send(enc_i(12'h403, 5'd1, 3'd5, 5'd9, OPC_OP_IMM_32), 64'h0000_0000_c000_0000, '0, '0,
         1'b0);
    send({20'h80001, 5'd10, OPC_LUI}, '0, '0, '0, 1'b0);
    send({20'h12345, 5'd11, OPC_AUIPC}, '0, '0, '0, 1'b0);
    send({20'h0abcd, 5'd12, OPC_JAL}, '0, '0, '0, 1'b0);
    send(enc_i(12'h010, 5'd1, 3'd0, 5'd13, OPC_JALR), {$urandom, $urandom}, '0, '0, 1'b0);
    end_test();
  endtask

  task automatic test_csr();
    logic [2:0] f3;
    start_test("csr");
    for (int k = 1; k < 8; k++) begin
      f3 = 3'(k);
      if (f3 != 3'd4) begin
        send(enc_i(12'h300, 5'd7, f3, 5'd5, OPC_SYSTEM), {$urandom, $urandom}, '0,
             {$urandom, $urandom}, 1'b0);
        if (f3[1]) begin // set and clear with a zero source field
          send(enc_i(12'h300, 5'd0, f3, 5'd6, OPC_SYSTEM), {$urandom, $urandom}, '0,
               {$urandom, $urandom}, 1'b0);
        end
      end
    end
    end_test();
  endtask

  task automatic test_faults();
    start_test("faults");
    send(32'h0010_0073, '0, '0, '0, 1'b0); // ebreak
    send(32'h0000_0073, '0, '0, '0, 1'b0); // ecall
    send(32'h0000_3083, '0, '0, '0, 1'b0); // ld, no memory path
    send(32'hffff_ffff, '0, '0, '0, 1'b0);
    end_test();
  endtask

  task automatic test_backpressure();
    inst_t inst;
    start_test("backpressure");
    stall_en = 1'b1;
    for (int k = 0; k < 200; k++) begin
      if (k % 4 == 3) inst = enc_i(12'h340, 5'($urandom), 3'd2, 5'($urandom), OPC_SYSTEM);
      else            inst = rand_alu_inst();
      send(inst, {$urandom, $urandom}, {$urandom, $urandom}, {$urandom, $urandom}, 1'b0);
    end
    end_test();
    stall_en = 1'b0;
  endtask

  task automatic test_latency();
    start_test("latency");
    for (int k = 0; k < 20; k++) begin
      send(rand_alu_inst(), {$urandom, $urandom}, {$urandom, $urandom}, '0, 1'b1);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(32'h5717));
    i_arst_n     = 1'b0;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_pc         = '0;
    i_rs1data    = '0;
    i_rs2data    = '0;
    i_csrrdata   = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    test_basic();
    test_word();
    test_csr();
    test_faults();
    test_backpressure();
    test_latency();
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rv64_ex_pipe.sv
// three stage execute path, register and csr files live outside, no hazard or redirect handling
module rv64_ex_pipe (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_inst_valid,
  input  rv64_pkg::inst_t     i_inst,
  input  rv64_pkg::word_t     i_pc,
  input  rv64_pkg::word_t     i_rs1data,
  input  rv64_pkg::word_t     i_rs2data,
  input  rv64_pkg::word_t     i_csrrdata,
  input  logic                i_ready,
  output logic                o_inst_ready,
  output logic                o_valid,
  output rv64_pkg::gpr_addr_t o_rd,
  output logic                o_gpr_wen,
  output rv64_pkg::word_t     o_gpr_wdata,
  output logic                o_csr_wen,
  output rv64_pkg::word_t     o_csr_wdata,
  output logic                o_ebreak,
  output logic                o_invalid
);

  import rv64_pkg::*;

  // decode to execute
  logic      dec_valid;
  logic      dec_ready;
  word_t     dec_pc;
  word_t     dec_rs1data;
  word_t     dec_rs2data;
  word_t     dec_csrrdata;
  word_t     dec_imm;
  logic      dec_src1_pc;
  src2_sel_t dec_src2_sel;
  alu_op_t   dec_alu_op;
  logic      dec_word_cut;
  csr_op_t   dec_csr_op;
  logic      dec_csr_uimm;
  gpr_addr_t dec_rd;
  logic      dec_gpr_wen;
  logic      dec_csr_wen;
  logic      dec_ebreak;
  logic      dec_invalid;

  // execute to result
  logic      exe_valid;
  logic      exe_ready;
  gpr_addr_t exe_rd;
  logic      exe_gpr_wen;
  logic      exe_csr_wen;
  logic      exe_csr_inst;
  word_t     exe_csrrdata;
  word_t     exe_alu_result;
  word_t     exe_csr_result;
  logic      exe_ebreak;
  logic      exe_invalid;

  rv64_decode u_decode (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_valid    (i_inst_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1data  (i_rs1data),
    .i_rs2data  (i_rs2data),
    .i_csrrdata (i_csrrdata),
    .i_ready    (dec_ready),
    .o_ready    (o_inst_ready),
    .o_valid    (dec_valid),
    .o_pc       (dec_pc),
    .o_rs1data  (dec_rs1data),
    .o_rs2data  (dec_rs2data),
    .o_csrrdata (dec_csrrdata),
    .o_imm      (dec_imm),
    .o_src1_pc  (dec_src1_pc),
    .o_src2_sel (dec_src2_sel),
    .o_alu_op   (dec_alu_op),
    .o_word_cut (dec_word_cut),
    .o_csr_op   (dec_csr_op),
    .o_csr_uimm (dec_csr_uimm),
    .o_rd       (dec_rd),
    .o_gpr_wen  (dec_gpr_wen),
    .o_csr_wen  (dec_csr_wen),
    .o_ebreak   (dec_ebreak),
    .o_invalid  (dec_invalid)
  );

  rv64_execute u_execute (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (dec_valid),
    .i_pc         (dec_pc),
    .i_rs1data    (dec_rs1data),
    .i_rs2data    (dec_rs2data),
    .i_csrrdata   (dec_csrrdata),
    .i_imm        (dec_imm),
    .i_src1_pc    (dec_src1_pc),
    .i_src2_sel   (dec_src2_sel),
    .i_alu_op     (dec_alu_op),
    .i_word_cut   (dec_word_cut),
    .i_csr_op     (dec_csr_op),
    .i_csr_uimm   (dec_csr_uimm),
    .i_rd         (dec_rd),
    .i_gpr_wen    (dec_gpr_wen),
    .i_csr_wen    (dec_csr_wen),
    .i_ebreak     (dec_ebreak),
    .i_invalid    (dec_invalid),
    .i_ready      (exe_ready),
    .o_ready      (dec_ready),
    .o_valid      (exe_valid),
    .o_rd         (exe_rd),
    .o_gpr_wen    (exe_gpr_wen),
    .o_csr_wen    (exe_csr_wen),
    .o_csr_inst   (exe_csr_inst),
    .o_csrrdata   (exe_csrrdata),
    .o_alu_result (exe_alu_result),
    .o_csr_result (exe_csr_result),
    .o_ebreak     (exe_ebreak),
    .o_invalid    (exe_invalid)
  );

  rv64_result u_result (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (exe_valid),
    .i_rd         (exe_rd),
    .i_gpr_wen    (exe_gpr_wen),
    .i_csr_wen    (exe_csr_wen),
    .i_csr_inst   (exe_csr_inst),
    .i_csrrdata   (exe_csrrdata),
    .i_alu_result (exe_alu_result),
    .i_csr_result (exe_csr_result),
    .i_ebreak     (exe_ebreak),
    .i_invalid    (exe_invalid),
    .i_ready      (i_ready),
    .o_ready      (exe_ready),
    .o_valid      (o_valid),
    .o_rd         (o_rd),
    .o_gpr_wen    (o_gpr_wen),
    .o_gpr_wdata  (o_gpr_wdata),
    .o_csr_wen    (o_csr_wen),
    .o_csr_wdata  (o_csr_wdata),
    .o_ebreak     (o_ebreak),
    .o_invalid    (o_invalid)
  );

endmodule

//--- rv64_result.sv
// result stage, x0 writes and writes of invalid instructions are dropped before retire
module rv64_result (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  rv64_pkg::gpr_addr_t i_rd,
  input  logic                i_gpr_wen,
  input  logic                i_csr_wen,
  input  logic                i_csr_inst,
  input  rv64_pkg::word_t     i_csrrdata,
  input  rv64_pkg::word_t     i_alu_result,
  input  rv64_pkg::word_t     i_csr_result,
  input  logic                i_ebreak,
  input  logic                i_invalid,
  input  logic                i_ready,
  output logic                o_ready,
  output logic                o_valid,
  output rv64_pkg::gpr_addr_t o_rd,
  output logic                o_gpr_wen,
  output rv64_pkg::word_t     o_gpr_wdata,
  output logic                o_csr_wen,
  output rv64_pkg::word_t     o_csr_wdata,
  output logic                o_ebreak,
  output logic                o_invalid
);

  import rv64_pkg::*;

  word_t gpr_wdata;
  logic  gpr_wen;
  logic  csr_wen;

  assign gpr_wdata = i_csr_inst ? i_csrrdata : i_alu_result; // csr ops return the old value
  assign gpr_wen   = i_gpr_wen && !i_invalid && (i_rd != 5'd0);
  assign csr_wen   = i_csr_wen && !i_invalid;

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid   <= 1'b0;
      o_gpr_wen <= 1'b0;
      o_csr_wen <= 1'b0;
      o_ebreak  <= 1'b0;
      o_invalid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_gpr_wen <= gpr_wen;
        o_csr_wen <= csr_wen;
        o_ebreak  <= i_ebreak;
        o_invalid <= i_invalid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_rd        <= i_rd;
      o_gpr_wdata <= gpr_wdata;
      o_csr_wdata <= i_csr_result;
    end
  end

  a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_gpr_wen && o_rd == 5'd0));

endmodule

//--- rv64_execute.sv
// execute stage, csr source is rs1 or zimm, results held while downstream stalls
module rv64_execute (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  rv64_pkg::word_t     i_pc,
  input  rv64_pkg::word_t     i_rs1data,
  input  rv64_pkg::word_t     i_rs2data,
  input  rv64_pkg::word_t     i_csrrdata,
  input  rv64_pkg::word_t     i_imm,
  input  logic                i_src1_pc,
  input  rv64_pkg::src2_sel_t i_src2_sel,
  input  rv64_pkg::alu_op_t   i_alu_op,
  input  logic                i_word_cut,
  input  rv64_pkg::csr_op_t   i_csr_op,
  input  logic                i_csr_uimm,
  input  rv64_pkg::gpr_addr_t i_rd,
  input  logic                i_gpr_wen,
  input  logic                i_csr_wen,
  input  logic                i_ebreak,
  input  logic                i_invalid,
  input  logic                i_ready,
  output logic                o_ready,
  output logic                o_valid,
  output rv64_pkg::gpr_addr_t o_rd,
  output logic                o_gpr_wen,
  output logic                o_csr_wen,
  output logic                o_csr_inst,
  output rv64_pkg::word_t     o_csrrdata,
  output rv64_pkg::word_t     o_alu_result,
  output rv64_pkg::word_t     o_csr_result,
  output logic                o_ebreak,
  output logic                o_invalid
);

  import rv64_pkg::*;

  word_t alu_result;
  word_t csr_src;
  word_t csr_new;

  rv64_alu u_alu (
    .i_rs1data    (i_rs1data),
    .i_pc         (i_pc),
    .i_rs2data    (i_rs2data),
    .i_imm        (i_imm),
    .i_src1_pc    (i_src1_pc),
    .i_src2_sel   (i_src2_sel),
    .i_alu_op     (i_alu_op),
    .i_word_cut   (i_word_cut),
    .o_alu_result (alu_result)
  );

  assign csr_src = i_csr_uimm ? i_imm : i_rs1data; // imm carries zimm here

  always_comb begin
    case (i_csr_op)
      CSR_RW:  csr_new = csr_src;
      CSR_RS:  csr_new = i_csrrdata | csr_src;
      CSR_RC:  csr_new = i_csrrdata & ~csr_src;
      default: csr_new = i_csrrdata;
    endcase
  end

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_rd         <= i_rd;
      o_gpr_wen    <= i_gpr_wen;
      o_csr_wen    <= i_csr_wen;
      o_csr_inst   <= (i_csr_op != CSR_NONE);
      o_csrrdata   <= i_csrrdata;
      o_alu_result <= alu_result;
      o_csr_result <= csr_new;
      o_ebreak     <= i_ebreak;
      o_invalid    <= i_invalid;
    end
  end

  // stalled output must not move
  a_hold_on_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid && !i_ready |=> o_valid && $stable({o_rd, o_gpr_wen, o_csr_wen, o_csr_inst,
      o_csrrdata, o_alu_result, o_csr_result, o_ebreak, o_invalid}));

endmodule

//--- rv64_decode.sv
// decode stage, operands come from the caller, unsupported encodings flag o_invalid and write nothing
module rv64_decode (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  rv64_pkg::inst_t     i_inst,
  input  rv64_pkg::word_t     i_pc,
  input  rv64_pkg::word_t     i_rs1data,
  input  rv64_pkg::word_t     i_rs2data,
  input  rv64_pkg::word_t     i_csrrdata,
  input  logic                i_ready,
  output logic                o_ready,
  output logic                o_valid,
  output rv64_pkg::word_t     o_pc,
  output rv64_pkg::word_t     o_rs1data,
  output rv64_pkg::word_t     o_rs2data,
  output rv64_pkg::word_t     o_csrrdata,
  output rv64_pkg::word_t     o_imm,
  output logic                o_src1_pc,
  output rv64_pkg::src2_sel_t o_src2_sel,
  output rv64_pkg::alu_op_t   o_alu_op,
  output logic                o_word_cut,
  output rv64_pkg::csr_op_t   o_csr_op,
  output logic                o_csr_uimm,
  output rv64_pkg::gpr_addr_t o_rd,
  output logic                o_gpr_wen,
  output logic                o_csr_wen,
  output logic                o_ebreak,
  output logic                o_invalid
);

  import rv64_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs1_field;
  logic       f7_zero;
  logic       f7_alt;
  logic       op_f7_ok;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      zimm;

  word_t     d_imm;
  logic      d_src1_pc;
  src2_sel_t d_src2_sel;
  alu_op_t   d_alu_op;
  logic      d_word_cut;
  csr_op_t   d_csr_op;
  logic      d_csr_uimm;
  logic      d_gpr_wen;
  logic      d_csr_wen;
  logic      d_ebreak;
  logic      d_invalid;

  // funct3 to alu op, alt picks sub or sra
  function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7    = i_inst[31:25];
  assign rs1_field = i_inst[19:15];

  assign f7_zero  = (funct7 == 7'b0000000);
  assign f7_alt   = (funct7 == 7'b0100000);
  assign op_f7_ok = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign zimm  = {59'b0, rs1_field};

  always_comb begin
    d_imm      = imm_i;
    d_src1_pc  = 1'b0;
    d_src2_sel = SRC2_IMM;
    d_alu_op   = ALU_ADD;
    d_word_cut = 1'b0;
    d_csr_op   = CSR_NONE;
    d_csr_uimm = 1'b0;
    d_gpr_wen  = 1'b1;
    d_csr_wen  = 1'b0;
    d_ebreak   = 1'b0;
    d_invalid  = 1'b0;
    case (opcode)
      OPC_OP: begin
        d_src2_sel = SRC2_RS2;
        d_alu_op   = f3_to_op(funct3, i_inst[30]);
        d_invalid  = !op_f7_ok;
      end
      OPC_OP_IMM: begin
        d_alu_op = f3_to_op(funct3, funct3 == 3'b101 && i_inst[30]);
        if (funct3 == 3'b001) begin
          d_invalid = (i_inst[31:26] != 6'b0); // 6 bit shamt
        end else if (funct3 == 3'b101) begin
          d_invalid = ({i_inst[31], i_inst[29:26]} != 5'b0);
        end
      end
      OPC_OP_32: begin
        d_src2_sel = SRC2_RS2;
        d_alu_op   = f3_to_op(funct3, i_inst[30]);
        d_word_cut = 1'b1;
        d_invalid  = !(op_f7_ok && (funct3 inside {3'b000, 3'b001, 3'b101}));
      end
      OPC_OP_IMM_32: begin
        d_alu_op   = f3_to_op(funct3, funct3 == 3'b101 && i_inst[30]);
        d_word_cut = 1'b1;
        d_invalid  = !(funct3 == 3'b000 || (funct3 == 3'b001 && f7_zero) ||
                       (funct3 == 3'b101 && (f7_zero || f7_alt)));
      end
      OPC_LUI: begin
        d_imm    = imm_u;
        d_alu_op = ALU_LUI;
      end
      OPC_AUIPC: begin
        d_imm     = imm_u;
        d_src1_pc = 1'b1;
      end
      OPC_JAL: begin
        d_imm      = imm_j; // target not used here, only the link
        d_src1_pc  = 1'b1;
        d_src2_sel = SRC2_FOUR;
      end
      OPC_JALR: begin
        d_src1_pc  = 1'b1;
        d_src2_sel = SRC2_FOUR;
        d_invalid  = (funct3 != 3'b000);
      end
      OPC_SYSTEM: begin
        d_imm = zimm;
        if (funct3[1:0] == 2'b00) begin
          d_gpr_wen = 1'b0;
          d_ebreak  = (i_inst == 32'h0010_0073);
          d_invalid = !d_ebreak; // ecall, mret and friends not handled
        end else begin
          d_csr_uimm = funct3[2];
          case (funct3[1:0])
            2'b01:   d_csr_op = CSR_RW;
            2'b10:   d_csr_op = CSR_RS;
            default: d_csr_op = CSR_RC;
          endcase
          // set or clear with a zero source leaves the csr alone
          d_csr_wen = (funct3[1:0] == 2'b01) || (rs1_field != 5'b0);
        end
      end
      default: d_invalid = 1'b1;
    endcase
    if (d_invalid) begin
      d_gpr_wen = 1'b0;
      d_csr_wen = 1'b0;
    end
  end

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_pc       <= i_pc;
      o_rs1data  <= i_rs1data;
      o_rs2data  <= i_rs2data;
      o_csrrdata <= i_csrrdata;
      o_imm      <= d_imm;
      o_src1_pc  <= d_src1_pc;
      o_src2_sel <= d_src2_sel;
      o_alu_op   <= d_alu_op;
      o_word_cut <= d_word_cut;
      o_csr_op   <= d_csr_op;
      o_csr_uimm <= d_csr_uimm;
      o_rd       <= i_inst[11:7];
      o_gpr_wen  <= d_gpr_wen;
      o_csr_wen  <= d_csr_wen;
      o_ebreak   <= d_ebreak;
      o_invalid  <= d_invalid;
    end
  end

  a_fault_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid |-> !(o_ebreak && o_invalid));

endmodule

//--- rv64_alu.sv
// combinational alu, word ops use a 5 bit shamt and sign-extend the low 32 bits
module rv64_alu (
  input  rv64_pkg::word_t     i_rs1data,
  input  rv64_pkg::word_t     i_pc,
  input  rv64_pkg::word_t     i_rs2data,
  input  rv64_pkg::word_t     i_imm,
  input  logic                i_src1_pc,
  input  rv64_pkg::src2_sel_t i_src2_sel,
  input  rv64_pkg::alu_op_t   i_alu_op,
  input  logic                i_word_cut,
  output rv64_pkg::word_t     o_alu_result
);

  import rv64_pkg::*;

  word_t       src1;
  word_t       src2;
  word_t       res;
  logic [5:0]  shamt;
  logic [31:0] src1_lo;

  assign src1 = i_src1_pc ? i_pc : i_rs1data;

  always_comb begin
    case (i_src2_sel)
      SRC2_RS2: src2 = i_rs2data;
      SRC2_IMM: src2 = i_imm;
      default:  src2 = 64'd4;
    endcase
  end

  assign shamt   = i_word_cut ? {1'b0, src2[4:0]} : src2[5:0];
  assign src1_lo = src1[31:0];

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  res = src1 + src2;
      ALU_SUB:  res = src1 - src2;
      ALU_SLL:  res = src1 << shamt;
      ALU_SLT:  res = {63'b0, $signed(src1) < $signed(src2)};
      ALU_SLTU: res = {63'b0, src1 < src2};
      ALU_XOR:  res = src1 ^ src2;
      ALU_SRL: begin
        if (i_word_cut) res = {32'b0, src1_lo >> shamt[4:0]}; // srlw sees only the low word
        else            res = src1 >> shamt;
      end
      ALU_SRA: begin
        if (i_word_cut) res = {32'b0, $signed(src1_lo) >>> shamt[4:0]};
        else            res = $signed(src1) >>> shamt;
      end
      ALU_OR:   res = src1 | src2;
      ALU_AND:  res = src1 & src2;
      ALU_LUI:  res = src2;
      default:  res = '0;
    endcase
  end

  assign o_alu_result = i_word_cut ? {{32{res[31]}}, res[31:0]} : res;

endmodule

//--- rv64_pkg.sv
// rv64i base integer ops only, no m extension, opcode values follow the unprivileged spec
package rv64_pkg;

  typedef logic [63:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [1:0]  src2_sel_t;
  typedef logic [2:0]  csr_op_t;

  // alu operations
  localparam alu_op_t ALU_ADD  = 5'd0;
  localparam alu_op_t ALU_SUB  = 5'd1;
  localparam alu_op_t ALU_SLL  = 5'd2;
  localparam alu_op_t ALU_SLT  = 5'd3;
  localparam alu_op_t ALU_SLTU = 5'd4;
  localparam alu_op_t ALU_XOR  = 5'd5;
  localparam alu_op_t ALU_SRL  = 5'd6;
  localparam alu_op_t ALU_SRA  = 5'd7;
  localparam alu_op_t ALU_OR   = 5'd8;
  localparam alu_op_t ALU_AND  = 5'd9;
  localparam alu_op_t ALU_LUI  = 5'd10; // operand 2 straight through

  // operand 2 source
  localparam src2_sel_t SRC2_RS2  = 2'd0;
  localparam src2_sel_t SRC2_IMM  = 2'd1;
  localparam src2_sel_t SRC2_FOUR = 2'd2; // link value pc + 4

  // csr update rule
  localparam csr_op_t CSR_NONE = 3'd0;
  localparam csr_op_t CSR_RW   = 3'd1;
  localparam csr_op_t CSR_RS   = 3'd2;
  localparam csr_op_t CSR_RC   = 3'd3;

  // major opcodes
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

endpackage
